/* Makefile */
VERILATOR ?= verilator
TOP       ?= fpu_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the FPU testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* src.f */
+incdir+verilog
verilog/fpu_pkg.sv
verilog/fpu_control.sv
verilog/fpu_addsub.sv
verilog/fpu_mul.sv
verilog/fpu_cvt.sv
verilog/fpu.sv
tb/fpu_checker.sv
tb/fpu_tb.sv

/* tb/fpu_checker.sv */
`default_nettype none

`include "fpu_settings.svh"

module fpu_checker (
  input logic              clk,
  input logic              arst_n,
  input logic              in_valid,
  input logic              out_valid,
  input fpu_pkg::fp_word_t out,
  input logic              fpu_rd,
  input logic              fpu_rs1,
  input logic              unsupported
);
  timeunit 1ns;
  timeprecision 1ps;

  // one result per strobe, a fixed number of edges later
  latency_a: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid == $past(in_valid, `FPU_LATENCY))
    else $error("out_valid does not follow in_valid by the pipeline latency");

  out_known_a: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid |-> !$isunknown(out))
    else $error("out has unknown bits while out_valid is high");

  reset_quiet_a: assert property (@(posedge clk)
    !arst_n |-> !(out_valid | fpu_rd | fpu_rs1 | unsupported))
    else $error("valid or routing flags high during reset");

endmodule

bind fpu fpu_checker u_checker (
  .clk         (clk),
  .arst_n      (arst_n),
  .in_valid    (in_valid),
  .out_valid   (out_valid),
  .out         (out),
  .fpu_rd      (fpu_rd),
  .fpu_rs1     (fpu_rs1),
  .unsupported (unsupported)
);

`default_nettype wire

/* tb/fpu_tb.sv */
`default_nettype none

`include "fpu_settings.svh"

module fpu_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import fpu_pkg::*;

  localparam int NUM_OPS        = 1500;
  localparam int TIMEOUT_CYCLES = NUM_OPS * 4 + 50;   // at most 4 cycles per op group

  typedef struct packed {
    fp_word_t word;
    logic     rd;
    logic     rs1;
    logic     unsup;
  } expect_t;

  logic     clk;
  logic     arst_n;
  logic     in_valid;
  fpu_op_e  fpu_op;
  fp_word_t in1;
  fp_word_t in2;
  logic     out_valid;
  fp_word_t out;
  logic     fpu_rd;
  logic     fpu_rs1;
  logic     unsupported;

  expect_t     pending[$];   // expected results in issue order
  logic [31:0] lcg_state;
  int          issued      = 0;
  int          checked     = 0;
  int          cycle_count = 0;

  fpu u_fpu (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_valid    (in_valid),
    .fpu_op      (fpu_op),
    .in1         (in1),
    .in2         (in2),
    .out_valid   (out_valid),
    .out         (out),
    .fpu_rd      (fpu_rd),
    .fpu_rs1     (fpu_rs1),
    .unsupported (unsupported)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ##################################################
  // random numbers and operands

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int pick(input int n);
    return int'((next_rand() >> 8) % n);   // upper bits, the low ones repeat fast
  endfunction

  function automatic fp_word_t random_double(input int exp_lo, input int exp_span);
    logic [31:0] hi;
    logic [31:0] lo;
    fp_exp_t     e;
    hi = next_rand();
    lo = next_rand();
    e  = fp_exp_t'(exp_lo + pick(exp_span));
    return {hi[31], e, hi[19:0], lo};
  endfunction

  function automatic fp_word_t random_long();
    logic signed [63:0] v;
    v = {next_rand(), next_rand()};
    return fp_word_t'(v >>> (2 + pick(60)));   // magnitude stays below 2^62
  endfunction

  // ##################################################
  // reference model

  function automatic expect_t expected_for(input logic [4:0] code, input fp_word_t a,
                                           input fp_word_t b);
    expect_t e;
    real     ra;
    real     rb;
    real     t;
    longint  li;
    e  = '0;
    ra = $bitstoreal(a);
    rb = $bitstoreal(b);
    case (code)
      5'd0: e.word = $realtobits(ra + rb);
      5'd1: e.word = $realtobits(ra - rb);
      5'd2: e.word = $realtobits(ra * rb);
      5'd5: begin
        t      = (ra < 0.0) ? -$floor(-ra) : $floor(ra);   // toward zero
        li     = longint'(t);
        e.word = fp_word_t'(li);
      end
      5'd6: begin
        li     = longint'(a);
        e.word = $realtobits(real'(li));
      end
      5'd7, 5'd8: e.word = a;
      default: e.word = '0;
    endcase
    e.rd    = (code <= 5'd4) || (code == 5'd6) || (code == 5'd8);
    e.rs1   = (code <= 5'd5) || (code == 5'd7);
    e.unsup = (code == 5'd3) || (code == 5'd4) || (code > 5'd8);
    return e;
  endfunction

  // ##################################################
  // checks

  task automatic end_with_failure();
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic compare_word(input string name, input fp_word_t got, input fp_word_t want);
    if (got !== want) begin
      $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, want);
      end_with_failure();
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("ERROR at %0t ns: %s = %b, expected %b", $time, name, got, want);
      end_with_failure();
    end
  endtask

  // outputs are stable at the falling edge
  task automatic next_cycle();
    expect_t e;
    @(negedge clk);
    if (out_valid) begin
      if (pending.size() == 0) begin
        $display("a result came out with no operation in flight at %0t ns", $time);
        end_with_failure();
      end else begin
        e = pending.pop_front();
        compare_word("out", out, e.word);
        compare_flag("fpu_rd", fpu_rd, e.rd);
        compare_flag("fpu_rs1", fpu_rs1, e.rs1);
        compare_flag("unsupported", unsupported, e.unsup);
        checked++;
      end
    end
  endtask

  task automatic issue_op(input logic [4:0] code, input fp_word_t a, input fp_word_t b);
    next_cycle();
    in_valid = 1'b1;
    fpu_op   = fpu_op_e'(code);
    in1      = a;
    in2      = b;
    pending.push_back(expected_for(code, a, b));
    issued++;
  endtask

  // one op with operands suited to it
  task automatic send_random_op();
    logic [4:0] code;
    fp_word_t   a;
    fp_word_t   b;
    int         sel;
    sel = pick(16);
    a   = random_double(fp_bias - 200, 401);
    b   = random_double(fp_bias - 200, 401);
    case (sel)
      0, 1, 2, 15: code = 5'd0;
      3, 4:        code = 5'd1;
      5, 6: begin   // near cancellation
        code = 5'(pick(2));
        b    = a ^ fp_word_t'(next_rand() & 32'h0000_00ff);
        if (pick(2) == 0) b[62:52] = a[62:52] - 11'd1;
        if (code == 5'd0) b[63] = ~a[63];
      end
      7, 8: code = 5'd2;
      9: begin
        code = 5'd5;
        a    = random_double(fp_bias - 8, 70);   // unbiased exponent -8 to 61
      end
      10: begin
        code = 5'd6;
        a    = random_long();
      end
      11: code = 5'd7;
      12: begin
        code = 5'd8;
        a    = {next_rand(), next_rand()};
      end
      13:      code = 5'(3 + pick(2));   // fdiv or fsqrt
      default: code = 5'(9 + pick(23));
    endcase
    issue_op(code, a, b);
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, %0d results outstanding", cycle_count,
               pending.size());
      end_with_failure();
    end
  end

  // ##################################################
  // stimulus

  initial begin
    lcg_state = 32'h6c65;
    arst_n    = 1'b0;
    in_valid  = 1'b0;
    fpu_op    = op_fadd;
    in1       = '0;
    in2       = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    for (int n = 0; n < NUM_OPS; n++) begin
      send_random_op();
      if (pick(8) == 0) send_random_op();   // back-to-back strobe
      repeat (1 + pick(2)) begin
        next_cycle();
        in_valid = 1'b0;
        fpu_op   = fpu_op_e'(5'(pick(32)));   // idle bus carries junk
        in1      = {next_rand(), next_rand()};
        in2      = {next_rand(), next_rand()};
      end
    end

    while (pending.size() > 0) next_cycle();
    repeat (`FPU_LATENCY + 2) next_cycle();

    if (checked != issued) begin
      $display("%0d operations issued but %0d results checked", issued, checked);
      end_with_failure();
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* verilog/fpu.sv */
`default_nettype none

module fpu (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              in_valid,
  input  fpu_pkg::fpu_op_e  fpu_op,
  input  fpu_pkg::fp_word_t in1,
  input  fpu_pkg::fp_word_t in2,
  output logic              out_valid,
  output fpu_pkg::fp_word_t out,
  output logic              fpu_rd,
  output logic              fpu_rs1,
  output logic              unsupported
);
  import fpu_pkg::*;

  logic     sub;
  logic     to_int;
  fp_word_t sum;       // stage 2 of each unit
  fp_word_t product;
  fp_word_t cvt_out;

  fpu_control u_control (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_valid    (in_valid),
    .fpu_op      (fpu_op),
    .in1         (in1),
    .sum         (sum),
    .product     (product),
    .cvt_out     (cvt_out),
    .sub         (sub),
    .to_int      (to_int),
    .out_valid   (out_valid),
    .out         (out),
    .fpu_rd      (fpu_rd),
    .fpu_rs1     (fpu_rs1),
    .unsupported (unsupported)
  );

  fpu_addsub u_addsub (
    .clk    (clk),
    .arst_n (arst_n),
    .in1    (in1),
    .in2    (in2),
    .sub    (sub),
    .sum    (sum)
  );

  fpu_mul u_mul (
    .clk     (clk),
    .arst_n  (arst_n),
    .in1     (in1),
    .in2     (in2),
    .product (product)
  );

  fpu_cvt u_cvt (
    .clk     (clk),
    .arst_n  (arst_n),
    .in1     (in1),
    .to_int  (to_int),
    .cvt_out (cvt_out)
  );

endmodule

`default_nettype wire

/* verilog/fpu_addsub.sv */
`default_nettype none

module fpu_addsub (
  input  logic              clk,
  input  logic              arst_n,
  input  fpu_pkg::fp_word_t in1,
  input  fpu_pkg::fp_word_t in2,
  input  logic              sub,
  output fpu_pkg::fp_word_t sum
);
  import fpu_pkg::*;

  fp_exp_t            exp_a;
  fp_exp_t            exp_b;
  fp_exp_t            exp_l;
  fp_exp_t            exp_s;
  logic               sign_b;
  logic               sign_l;
  logic               sign_s;
  logic [62:0]        mag_a;
  logic [62:0]        mag_b;
  logic [52:0]        sig_a;
  logic [52:0]        sig_b;
  logic [52:0]        sig_l;
  logic [52:0]        sig_s;
  logic               swap;
  logic [10:0]        shift;
  logic [107:0]       shift_wide;
  logic               sticky;
  logic               eff_sub;
  logic [56:0]        raw_sum;
  logic               sign_q;
  fp_exp_t            exp_q;
  logic [56:0]        sum_q;
  logic [6:0]         lz;
  logic [56:0]        norm;
  logic signed [12:0] exp_norm;
  logic               round_up;
  logic [53:0]        rounded;
  logic signed [12:0] exp_out;

  // ##################################################
  // stage 1 aligns and adds

  assign exp_a  = in1[62:52];
  assign exp_b  = in2[62:52];
  assign sign_b = in2[63] ^ sub;   // subtract by flipping the second sign

  // subnormals count as zero
  assign mag_a = (exp_a == '0) ? '0 : in1[62:0];
  assign mag_b = (exp_b == '0) ? '0 : in2[62:0];
  assign sig_a = (exp_a == '0) ? '0 : {1'b1, fp_man_t'(in1[51:0])};
  assign sig_b = (exp_b == '0) ? '0 : {1'b1, fp_man_t'(in2[51:0])};

  assign swap   = mag_b > mag_a;   // larger magnitude goes first
  assign sign_l = swap ? sign_b : in1[63];
  assign sign_s = swap ? in1[63] : sign_b;
  assign exp_l  = swap ? exp_b : exp_a;
  assign exp_s  = swap ? exp_a : exp_b;
  assign sig_l  = swap ? sig_b : sig_a;
  assign sig_s  = swap ? sig_a : sig_b;

  assign shift      = exp_l - exp_s;
  assign shift_wide = {sig_s, 55'b0} >> shift;
  assign sticky     = (shift > 11'd55) ? |sig_s : |shift_wide[52:0];
  assign eff_sub    = sign_l ^ sign_s;

  // bit 56 carry, 55 hidden one, 2..0 guard round sticky
  assign raw_sum = eff_sub ? {1'b0, sig_l, 3'b000} - {1'b0, shift_wide[107:53], sticky}
                           : {1'b0, sig_l, 3'b000} + {1'b0, shift_wide[107:53], sticky};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sign_q <= 1'b0;
    end else begin
      sign_q <= sign_l & ~(eff_sub & (raw_sum == '0));   // +0 on exact cancel
    end
  end

  always_ff @(posedge clk) begin
    exp_q <= exp_l;
    sum_q <= raw_sum;
  end

  // ##################################################
  // stage 2 normalizes and rounds

  assign lz       = lzc64({sum_q, 7'b0});
  assign norm     = sum_q << lz;   // leading one lands on bit 56
  assign exp_norm = $signed({2'b00, exp_q}) + 13'sd1 - $signed({6'b0, lz});
  assign round_up = norm[3] & (|norm[2:0] | norm[4]);
  assign rounded  = {1'b0, norm[56:4]} + 54'(round_up);
  assign exp_out  = exp_norm + $signed({12'b0, rounded[53]});   // carry out of rounding

  always_ff @(posedge clk) begin
    if (sum_q == '0 || exp_out <= 0) begin
      sum <= {sign_q, 63'b0};   // flush underflow to zero
    end else if (exp_out >= 13'sd2047) begin
      sum <= {sign_q, 11'h7ff, 52'b0};
    end else begin
      sum <= {sign_q, exp_out[10:0], rounded[51:0]};
    end
  end

endmodule

`default_nettype wire

/* verilog/fpu_control.sv */
`default_nettype none

module fpu_control (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              in_valid,
  input  fpu_pkg::fpu_op_e  fpu_op,
  input  fpu_pkg::fp_word_t in1,
  input  fpu_pkg::fp_word_t sum,
  input  fpu_pkg::fp_word_t product,
  input  fpu_pkg::fp_word_t cvt_out,
  output logic              sub,
  output logic              to_int,
  output logic              out_valid,
  output fpu_pkg::fp_word_t out,
  output logic              fpu_rd,
  output logic              fpu_rs1,
  output logic              unsupported
);
  import fpu_pkg::*;

  logic     valid_q1;
  fpu_op_e  op_q1;
  fpu_op_e  op_q2;
  fp_word_t in1_q1;   // kept for the move ops
  fp_word_t in1_q2;
  logic     rd_d;
  logic     rs1_d;
  logic     unsup_d;

  // unit controls are decoded straight from the issue port
  assign sub    = (fpu_op == op_fsub);
  assign to_int = (fpu_op == op_fcvt_l_d);

  // ##################################################
  // valid, op and flag pipeline

  always_comb begin
    rd_d    = 1'b0;
    rs1_d   = 1'b0;
    unsup_d = 1'b0;
    case (op_q1)
      op_fadd, op_fsub, op_fmul: begin
        rd_d  = 1'b1;
        rs1_d = 1'b1;
      end
      op_fdiv, op_fsqrt: begin
        rd_d    = 1'b1;
        rs1_d   = 1'b1;
        unsup_d = 1'b1;
      end
      op_fcvt_l_d, op_fmv_x_d: rs1_d = 1'b1;   // integer destination
      op_fcvt_d_l, op_fmv_d_x: rd_d  = 1'b1;   // integer source
      default:                 unsup_d = 1'b1;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q1    <= 1'b0;
      out_valid   <= 1'b0;
      op_q1       <= op_fadd;
      op_q2       <= op_fadd;
      fpu_rd      <= 1'b0;
      fpu_rs1     <= 1'b0;
      unsupported <= 1'b0;
    end else begin
      valid_q1    <= in_valid;
      out_valid   <= valid_q1;
      op_q1       <= fpu_op;
      op_q2       <= op_q1;
      fpu_rd      <= valid_q1 & rd_d;    // quiet when idle
      fpu_rs1     <= valid_q1 & rs1_d;
      unsupported <= valid_q1 & unsup_d;
    end
  end

  always_ff @(posedge clk) begin
    in1_q1 <= in1;
    in1_q2 <= in1_q1;
  end

  // ##################################################
  // result select from the stage 2 outputs

  always_comb begin
    case (op_q2)
      op_fadd, op_fsub:         out = sum;
      op_fmul:                  out = product;
      op_fcvt_l_d, op_fcvt_d_l: out = cvt_out;
      op_fmv_x_d, op_fmv_d_x:   out = in1_q2;   // plain bit copy
      default:                  out = '0;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/fpu_cvt.sv */
`default_nettype none

module fpu_cvt (
  input  logic              clk,
  input  logic              arst_n,
  input  fpu_pkg::fp_word_t in1,
  input  logic              to_int,
  output fpu_pkg::fp_word_t cvt_out
);
  import fpu_pkg::*;

  fp_exp_t            exp_in;
  fp_man_t            frac_in;
  logic signed [12:0] exp_unb;
  fp_word_t           sig_wide;
  fp_word_t           int_mag;
  fp_word_t           abs_in;
  logic               to_int_q;
  logic               sign_q;
  logic               sat_q;
  fp_word_t           mag_q;   // shifted magnitude or absolute long
  logic [6:0]         lz_q;
  fp_word_t           int_res;
  fp_word_t           norm;
  logic               round_up;
  logic [53:0]        rounded;
  fp_exp_t            exp_out;
  fp_word_t           fp_res;

  // ##################################################
  // stage 1

  assign exp_in   = in1[62:52];
  assign frac_in  = in1[51:0];
  assign exp_unb  = $signed({2'b00, exp_in}) - 13'(fp_bias);
  assign sig_wide = {11'b0, 1'b1, frac_in};
  assign abs_in   = in1[63] ? -in1 : in1;

  // fraction bits fall off the bottom, so this truncates toward zero
  always_comb begin
    if (exp_unb < 0) begin
      int_mag = '0;
    end else if (exp_unb >= 13'sd52) begin
      int_mag = sig_wide << 6'(exp_unb - 13'sd52);
    end else begin
      int_mag = sig_wide >> 6'(13'sd52 - exp_unb);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      to_int_q <= 1'b0;
      sign_q   <= 1'b0;
      sat_q    <= 1'b0;
    end else begin
      to_int_q <= to_int;
      sign_q   <= in1[63];
      sat_q    <= exp_unb > 13'sd62;   // beyond long range
    end
  end

  always_ff @(posedge clk) begin
    mag_q <= to_int ? int_mag : abs_in;
    lz_q  <= lzc64(abs_in);
  end

  // ##################################################
  // stage 2

  always_comb begin
    if (sat_q) begin
      int_res = sign_q ? 64'h8000_0000_0000_0000 : 64'h7fff_ffff_ffff_ffff;
    end else begin
      int_res = sign_q ? -mag_q : mag_q;
    end
  end

  assign norm     = mag_q << lz_q;   // leading one on bit 63
  assign round_up = norm[10] & (|norm[9:0] | norm[11]);
  assign rounded  = {1'b0, norm[63:11]} + 54'(round_up);
  assign exp_out  = 11'(fp_bias + 63) - 11'(lz_q) + 11'(rounded[53]);
  assign fp_res   = (mag_q == '0) ? '0 : {sign_q, exp_out, rounded[51:0]};

  always_ff @(posedge clk) begin
    cvt_out <= to_int_q ? int_res : fp_res;
  end

endmodule

`default_nettype wire

/* verilog/fpu_mul.sv */
`default_nettype none

module fpu_mul (
  input  logic              clk,
  input  logic              arst_n,
  input  fpu_pkg::fp_word_t in1,
  input  fpu_pkg::fp_word_t in2,
  output fpu_pkg::fp_word_t product
);
  import fpu_pkg::*;

  fp_exp_t            exp_a;
  fp_exp_t            exp_b;
  logic [52:0]        sig_a;
  logic [52:0]        sig_b;
  logic               sign_q;
  logic               zero_q;
  logic signed [12:0] exp_q;
  logic [105:0]       prod_q;
  logic [105:0]       norm;
  logic signed [12:0] exp_norm;
  logic               round_up;
  logic [53:0]        rounded;
  logic signed [12:0] exp_out;

  // ##################################################
  // stage 1 multiplies the significands

  assign exp_a = in1[62:52];
  assign exp_b = in2[62:52];
  assign sig_a = {1'b1, fp_man_t'(in1[51:0])};
  assign sig_b = {1'b1, fp_man_t'(in2[51:0])};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sign_q <= 1'b0;
      zero_q <= 1'b0;
    end else begin
      sign_q <= in1[63] ^ in2[63];
      zero_q <= (exp_a == '0) || (exp_b == '0);   // subnormal counts as zero
    end
  end

  always_ff @(posedge clk) begin
    exp_q  <= $signed({2'b00, exp_a}) + $signed({2'b00, exp_b}) - 13'(fp_bias);
    prod_q <= sig_a * sig_b;   // value in [1, 4)
  end

  // ##################################################
  // stage 2 normalizes by one and rounds

  assign norm     = prod_q[105] ? prod_q : {prod_q[104:0], 1'b0};
  assign exp_norm = exp_q + $signed({12'b0, prod_q[105]});
  assign round_up = norm[52] & (|norm[51:0] | norm[53]);
  assign rounded  = {1'b0, norm[105:53]} + 54'(round_up);
  assign exp_out  = exp_norm + $signed({12'b0, rounded[53]});

  always_ff @(posedge clk) begin
    if (zero_q || exp_out <= 0) begin
      product <= {sign_q, 63'b0};   // signed zero
    end else if (exp_out >= 13'sd2047) begin
      product <= {sign_q, 11'h7ff, 52'b0};   // saturate to infinity
    end else begin
      product <= {sign_q, exp_out[10:0], rounded[51:0]};
    end
  end

endmodule

`default_nettype wire

/* verilog/fpu_pkg.sv */
`default_nettype none

`include "fpu_settings.svh"

package fpu_pkg;

  typedef enum logic [`FPU_OP_W-1:0] {
    op_fadd     = 0,
    op_fsub     = 1,
    op_fmul     = 2,
    op_fdiv     = 3,  // not implemented, returns zero
    op_fsqrt    = 4,  // not implemented, returns zero
    op_fcvt_l_d = 5,
    op_fcvt_d_l = 6,
    op_fmv_x_d  = 7,
    op_fmv_d_x  = 8
  } fpu_op_e;

  typedef logic [10:0]          fp_exp_t;   // biased exponent
  typedef logic [51:0]          fp_man_t;   // stored fraction, hidden one implied
  typedef logic [`FPU_XLEN-1:0] fp_word_t;

  localparam int fp_bias = 1023;

  // leading zeros of a full word, 64 for an all-zero word
  function automatic logic [6:0] lzc64(input fp_word_t v);
    logic [6:0] n;
    logic       found;
    n     = 7'd64;
    found = 1'b0;
    for (int i = 63; i >= 0; i--) begin
      if (v[i] && !found) begin
        n     = 7'(63 - i);
        found = 1'b1;
      end
    end
    return n;
  endfunction

endpackage

`default_nettype wire

/* verilog/fpu_settings.svh */
`ifndef FPU_SETTINGS_SVH
`define FPU_SETTINGS_SVH

// operand and result width
`define FPU_XLEN 64

// operation code width from the issue stage
`define FPU_OP_W 5

// cycles from in_valid to out_valid
`define FPU_LATENCY 2

`endif
